//--- src/echo_defines.svh
`ifndef ECHO_DEFINES_SVH
`define ECHO_DEFINES_SVH

// Ethernet, IPv4 and UDP header length in bytes
`define HDR_BYTES 42

// Reply payload buffer entries
`define FIFO_DEPTH 64

// Local station addresses
`define LOCAL_MAC 48'h02_00_00_00_00_00
`define LOCAL_IP 32'hC0_A8_01_80

// UDP port answered by the responder
`define ECHO_PORT 16'd1234

// TTL placed in every reply
`define REPLY_TTL 8'd64

// Protocol constants
`define ETH_TYPE_IPV4 16'h0800
`define IPV4_VER_IHL 8'h45
`define IP_PROTO_UDP 8'd17

`endif

//--- src/net_hdr_pkg.sv
`include "echo_defines.svh"

package net_hdr_pkg;

    // Field view, first wire byte in the top bits
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
        logic [7:0]  ver_ihl;
        logic [7:0]  tos;
        logic [15:0] total_len;
        logic [15:0] ip_id;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] ip_csum;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_len;
        logic [15:0] udp_csum;
    } eth_ip_udp_hdr_t;

    // Byte view, element 0 is the first byte on the wire
    typedef logic [0:`HDR_BYTES-1][7:0] hdr_bytes_t;

    typedef union packed {
        eth_ip_udp_hdr_t fields;
        hdr_bytes_t      bytes;
    } hdr_word_u;

endpackage

//--- src/echo_ctl_pkg.sv
package echo_ctl_pkg;

    // Byte position within the 42-byte header
    typedef logic [5:0] hdr_idx_t;

    // Parser phases
    typedef enum logic [1:0] {
        PS_HDR  = 2'd0,
        PS_HOLD = 2'd1,
        PS_PAY  = 2'd2
    } parse_state_t;

endpackage

//--- src/frame_header_parser.sv
`include "echo_defines.svh"

module frame_header_parser (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [7:0]             in_data,
    input  logic                   in_valid,
    input  logic                   in_last,
    output logic                   in_ready,
    output net_hdr_pkg::hdr_word_u hdr_word,
    output logic                   hdr_valid,
    input  logic                   hdr_ready,
    output logic [7:0]             pay_data,
    output logic                   pay_valid,
    output logic                   pay_last,
    input  logic                   pay_ready
);
    import echo_ctl_pkg::*;

    localparam hdr_idx_t LAST_IDX = hdr_idx_t'(`HDR_BYTES - 1);

    parse_state_t state;
    hdr_idx_t     cnt;
    logic         in_fire;

    assign in_fire = in_valid && in_ready;

    always_comb begin
        case (state)
            PS_HDR:  in_ready = 1'b1;
            PS_PAY:  in_ready = pay_ready;
            default: in_ready = 1'b0;
        endcase
    end

    assign hdr_valid = (state == PS_HOLD);

    // Payload passes straight through once the header is taken
    assign pay_data  = in_data;
    assign pay_valid = (state == PS_PAY) && in_valid;
    assign pay_last  = in_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= PS_HDR;
            cnt   <= '0;
        end else begin
            case (state)
                PS_HDR: begin
                    if (in_fire) begin
                        if (in_last) begin
                            // Runt frame, start over
                            cnt <= '0;
                        end else if (cnt == LAST_IDX) begin
                            cnt   <= '0;
                            state <= PS_HOLD;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                PS_HOLD: begin
                    if (hdr_ready) begin
                        state <= PS_PAY;
                    end
                end
                PS_PAY: begin
                    if (in_fire && in_last) begin
                        state <= PS_HDR;
                    end
                end
                default: state <= PS_HDR;
            endcase
        end
    end

    // Header bytes shift in from the end of the byte view
    always_ff @(posedge clk) begin
        if (state == PS_HDR && in_fire) begin
            hdr_word.bytes <= {hdr_word.bytes[1:`HDR_BYTES-1], in_data};
        end
    end

    a_hdr_stable: assert property (@(posedge clk) disable iff (rst)
        hdr_valid && !hdr_ready |=> hdr_valid && $stable(hdr_word));

endmodule

//--- src/echo_port_filter.sv
`include "echo_defines.svh"

module echo_port_filter (
    input  logic                   clk,
    input  logic                   rst,
    input  net_hdr_pkg::hdr_word_u hdr_word,
    input  logic                   hdr_valid,
    output logic                   hdr_ready,
    input  logic [7:0]             pay_data,
    input  logic                   pay_valid,
    input  logic                   pay_last,
    output logic                   pay_ready,
    output logic [7:0]             fifo_in_data,
    output logic                   fifo_in_valid,
    output logic                   fifo_in_last,
    input  logic                   fifo_in_ready,
    output net_hdr_pkg::hdr_word_u req_hdr,
    output logic                   req_valid,
    input  logic                   req_ready
);

    logic is_echo;
    logic keep;

    // Plain IPv4 UDP to our address and echo port
    assign is_echo = (hdr_word.fields.eth_type == `ETH_TYPE_IPV4)
                  && (hdr_word.fields.ver_ihl == `IPV4_VER_IHL)
                  && (hdr_word.fields.protocol == `IP_PROTO_UDP)
                  && (hdr_word.fields.dst_ip == `LOCAL_IP)
                  && (hdr_word.fields.dst_port == `ECHO_PORT);

    assign req_hdr   = hdr_word;
    assign req_valid = hdr_valid && is_echo;

    // Everything else is swallowed at once
    assign hdr_ready = is_echo ? req_ready : 1'b1;

    assign fifo_in_data  = pay_data;
    assign fifo_in_last  = pay_last;
    assign fifo_in_valid = pay_valid && keep;
    assign pay_ready     = keep ? fifo_in_ready : 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            keep <= 1'b0;
        end else if (hdr_valid && hdr_ready) begin
            keep <= is_echo;
        end else if (pay_valid && pay_ready && pay_last) begin
            keep <= 1'b0;
        end
    end

    // A kept payload never overlaps the next header
    a_keep_window: assert property (@(posedge clk) disable iff (rst)
        fifo_in_valid |-> keep && !hdr_valid);

endmodule

//--- src/payload_fifo.sv
`include "echo_defines.svh"

module payload_fifo (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] wr_data,
    input  logic       wr_last,
    input  logic       wr_valid,
    output logic       wr_ready,
    output logic [7:0] rd_data,
    output logic       rd_last,
    output logic       rd_valid,
    input  logic       rd_ready
);

    localparam int DEPTH = `FIFO_DEPTH;
    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

    // Byte plus last flag per entry
    logic [8:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_fire;
    logic          rd_fire;

    assign wr_ready = (count != FULL_COUNT);
    assign rd_valid = (count != '0);
    assign {rd_last, rd_data} = mem[rd_ptr];

    assign wr_fire = wr_valid && wr_ready;
    assign rd_fire = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= {wr_last, wr_data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        count <= FULL_COUNT);

endmodule

//--- src/reply_framer.sv
`include "echo_defines.svh"

module reply_framer (
    input  logic                   clk,
    input  logic                   rst,
    input  net_hdr_pkg::hdr_word_u req_hdr,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  logic [7:0]             fifo_out_data,
    input  logic                   fifo_out_last,
    input  logic                   fifo_out_valid,
    output logic                   fifo_out_ready,
    output logic [7:0]             out_data,
    output logic                   out_valid,
    output logic                   out_last,
    input  logic                   out_ready,
    output logic [7:0]             led
);
    import net_hdr_pkg::*;
    import echo_ctl_pkg::*;

    localparam hdr_idx_t LAST_IDX = hdr_idx_t'(`HDR_BYTES - 1);
    localparam logic [31:0] SRC_IP = `LOCAL_IP;

    hdr_word_u   reply_d;
    hdr_word_u   reply_q;
    hdr_idx_t    pos;
    logic        send_hdr;
    logic        send_pay;
    logic        first_pay;
    logic        out_fire;
    logic [19:0] ip_sum;
    logic [16:0] ip_fold;

    // Identification, flags and checksum words are zero and drop out
    assign ip_sum = 20'({`IPV4_VER_IHL, 8'h00})
                  + 20'(req_hdr.fields.total_len)
                  + 20'({`REPLY_TTL, `IP_PROTO_UDP})
                  + 20'(SRC_IP[31:16]) + 20'(SRC_IP[15:0])
                  + 20'(req_hdr.fields.src_ip[31:16])
                  + 20'(req_hdr.fields.src_ip[15:0]);
    assign ip_fold = {1'b0, ip_sum[15:0]} + 17'(ip_sum[19:16]);

    always_comb begin
        reply_d = '0;
        reply_d.fields.dst_mac   = req_hdr.fields.src_mac;
        reply_d.fields.src_mac   = `LOCAL_MAC;
        reply_d.fields.eth_type  = `ETH_TYPE_IPV4;
        reply_d.fields.ver_ihl   = `IPV4_VER_IHL;
        reply_d.fields.total_len = req_hdr.fields.total_len;
        reply_d.fields.ttl       = `REPLY_TTL;
        reply_d.fields.protocol  = `IP_PROTO_UDP;
        reply_d.fields.ip_csum   = ~(ip_fold[15:0] + 16'(ip_fold[16]));
        reply_d.fields.src_ip    = SRC_IP;
        reply_d.fields.dst_ip    = req_hdr.fields.src_ip;
        reply_d.fields.src_port  = req_hdr.fields.dst_port;
        reply_d.fields.dst_port  = req_hdr.fields.src_port;
        reply_d.fields.udp_len   = req_hdr.fields.udp_len;
    end

    assign req_ready = !send_hdr && !send_pay;

    // Header bytes first, then the buffered payload
    assign out_data       = send_pay ? fifo_out_data : reply_q.bytes[pos];
    assign out_valid      = send_hdr || (send_pay && fifo_out_valid);
    assign out_last       = send_pay && fifo_out_valid && fifo_out_last;
    assign fifo_out_ready = send_pay && out_ready;
    assign out_fire       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            reply_q <= reply_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            send_hdr  <= 1'b0;
            send_pay  <= 1'b0;
            first_pay <= 1'b0;
            pos       <= '0;
            led       <= '0;
        end else if (req_valid && req_ready) begin
            send_hdr <= 1'b1;
            pos      <= '0;
        end else if (send_hdr && out_fire) begin
            if (pos == LAST_IDX) begin
                send_hdr  <= 1'b0;
                send_pay  <= 1'b1;
                first_pay <= 1'b1;
            end else begin
                pos <= pos + 1'b1;
            end
        end else if (send_pay && out_fire) begin
            // Show the first payload byte of the reply
            if (first_pay) begin
                led <= fifo_out_data;
            end
            first_pay <= 1'b0;
            if (fifo_out_last) begin
                send_pay <= 1'b0;
            end
        end
    end

    // Stalled output holds, including bytes coming from the FIFO
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last));

endmodule

//--- src/udp_echo_top.sv
module udp_echo_top (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] in_data,
    input  logic       in_valid,
    input  logic       in_last,
    output logic       in_ready,
    output logic [7:0] out_data,
    output logic       out_valid,
    output logic       out_last,
    input  logic       out_ready,
    output logic [7:0] led
);
    import net_hdr_pkg::*;

    hdr_word_u  hdr_word;
    logic       hdr_valid;
    logic       hdr_ready;
    logic [7:0] pay_data;
    logic       pay_valid;
    logic       pay_ready;
    logic       pay_last;

    logic [7:0] fifo_in_data;
    logic       fifo_in_valid;
    logic       fifo_in_ready;
    logic       fifo_in_last;

    hdr_word_u  req_hdr;
    logic       req_valid;
    logic       req_ready;

    logic [7:0] fifo_out_data;
    logic       fifo_out_valid;
    logic       fifo_out_ready;
    logic       fifo_out_last;

    frame_header_parser i_frame_header_parser (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_ready  (in_ready),
        .hdr_word  (hdr_word),
        .hdr_valid (hdr_valid),
        .hdr_ready (hdr_ready),
        .pay_data  (pay_data),
        .pay_valid (pay_valid),
        .pay_last  (pay_last),
        .pay_ready (pay_ready)
    );

    echo_port_filter i_echo_port_filter (
        .clk           (clk),
        .rst           (rst),
        .hdr_word      (hdr_word),
        .hdr_valid     (hdr_valid),
        .hdr_ready     (hdr_ready),
        .pay_data      (pay_data),
        .pay_valid     (pay_valid),
        .pay_last      (pay_last),
        .pay_ready     (pay_ready),
        .fifo_in_data  (fifo_in_data),
        .fifo_in_valid (fifo_in_valid),
        .fifo_in_last  (fifo_in_last),
        .fifo_in_ready (fifo_in_ready),
        .req_hdr       (req_hdr),
        .req_valid     (req_valid),
        .req_ready     (req_ready)
    );

    // Holds request payload while the reply header goes out
    payload_fifo i_payload_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (fifo_in_data),
        .wr_last  (fifo_in_last),
        .wr_valid (fifo_in_valid),
        .wr_ready (fifo_in_ready),
        .rd_data  (fifo_out_data),
        .rd_last  (fifo_out_last),
        .rd_valid (fifo_out_valid),
        .rd_ready (fifo_out_ready)
    );

    reply_framer i_reply_framer (
        .clk            (clk),
        .rst            (rst),
        .req_hdr        (req_hdr),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .fifo_out_data  (fifo_out_data),
        .fifo_out_last  (fifo_out_last),
        .fifo_out_valid (fifo_out_valid),
        .fifo_out_ready (fifo_out_ready),
        .out_data       (out_data),
        .out_valid      (out_valid),
        .out_last       (out_last),
        .out_ready      (out_ready),
        .led            (led)
    );

endmodule

//--- sim/udp_echo_tb.sv
module udp_echo_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [7:0] byte_q_t[$];

    localparam logic [47:0] LOCAL_MAC = 48'h02_00_00_00_00_00;
    localparam logic [31:0] LOCAL_IP  = 32'hC0_A8_01_80;
    localparam logic [15:0] ECHO_PORT = 16'd1234;
    localparam logic [7:0]  REPLY_TTL = 8'd64;
    // Remote station that sends the requests
    localparam logic [47:0] PEER_MAC  = 48'h0A_1B_2C_3D_4E_5F;
    localparam logic [31:0] PEER_IP   = 32'h0A_00_00_07;
    localparam logic [15:0] PEER_PORT = 16'hC350;
    localparam int NUM_TESTS       = 5;
    localparam int WATCHDOG_CYCLES = 4000 + 200 * NUM_TESTS;

    logic       clk;
    logic       rst;
    logic [7:0] in_data;
    logic       in_valid;
    logic       in_last;
    logic       in_ready;
    logic [7:0] out_data;
    logic       out_valid;
    logic       out_last;
    logic       out_ready;
    logic [7:0] led;

    logic [31:0] lfsr_state = 32'h6bb99072;
    logic        stall_en = 1'b0;
    logic        led_pending = 1'b0;
    logic [8:0]  got_q[$];
    logic [8:0]  exp_q[$];
    logic [7:0]  led_q[$];
    logic [7:0]  exp_led_q[$];

    udp_echo_top i_udp_echo_top (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready),
        .led       (led)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] lfsr_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_bit()};
        end
        return b;
    endfunction

    task automatic random_payload(input int n, output byte_q_t p);
        p = {};
        for (int i = 0; i < n; i++) begin
            p.push_back(lfsr_byte());
        end
    endtask

    // Big-endian field, most significant byte first on the wire
    function automatic void put_be(inout byte_q_t q, input logic [47:0] v, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            q.push_back(v[8*i +: 8]);
        end
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s: got %0h, expected %0h", $time, what, actual,
                     expected);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic build_request(input logic [31:0] dst_ip, input logic [15:0] eth_type,
                                 input logic [7:0] proto, input logic [15:0] dst_port,
                                 input byte_q_t pay, output byte_q_t f);
        f = {};
        put_be(f, LOCAL_MAC, 6);
        put_be(f, PEER_MAC, 6);
        put_be(f, 48'(eth_type), 2);
        f.push_back(8'h45);
        f.push_back(8'h00);
        put_be(f, 48'(28 + pay.size()), 2);
        // Nonzero id, flags and TTL that the reply must not copy
        put_be(f, 48'h1C46, 2);
        put_be(f, 48'h4000, 2);
        f.push_back(8'h80);
        f.push_back(proto);
        put_be(f, 48'h0, 2);
        put_be(f, 48'(PEER_IP), 4);
        put_be(f, 48'(dst_ip), 4);
        put_be(f, 48'(PEER_PORT), 2);
        put_be(f, 48'(dst_port), 2);
        put_be(f, 48'(8 + pay.size()), 2);
        put_be(f, 48'h0, 2);
        foreach (pay[i]) f.push_back(pay[i]);
    endtask

    // Reference reply for a request from the peer station
    task automatic expect_reply(input byte_q_t pay);
        byte_q_t     r;
        logic [31:0] sum;
        r = {};
        put_be(r, PEER_MAC, 6);
        put_be(r, LOCAL_MAC, 6);
        put_be(r, 48'h0800, 2);
        r.push_back(8'h45);
        r.push_back(8'h00);
        put_be(r, 48'(28 + pay.size()), 2);
        put_be(r, 48'h0, 4);
        r.push_back(REPLY_TTL);
        r.push_back(8'd17);
        put_be(r, 48'h0, 2);
        put_be(r, 48'(LOCAL_IP), 4);
        put_be(r, 48'(PEER_IP), 4);
        put_be(r, 48'(ECHO_PORT), 2);
        put_be(r, 48'(PEER_PORT), 2);
        put_be(r, 48'(8 + pay.size()), 2);
        put_be(r, 48'h0, 2);
        // IP header occupies bytes 14 to 33
        sum = '0;
        for (int i = 14; i < 34; i += 2) begin
            sum = sum + {16'h0, r[i], r[i+1]};
        end
        sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        r[24] = ~sum[15:8];
        r[25] = ~sum[7:0];
        foreach (pay[i]) r.push_back(pay[i]);
        foreach (r[i]) exp_q.push_back({i == r.size() - 1, r[i]});
        exp_led_q.push_back(pay[0]);
    endtask

    // Called on a rising edge, returns on the edge that takes the last byte
    task automatic send_frame(input byte_q_t f);
        logic taken;
        foreach (f[i]) begin
            in_data  <= f[i];
            in_last  <= (i == f.size() - 1);
            in_valid <= 1'b1;
            do begin
                @(negedge clk);
                taken = in_ready;
                @(posedge clk);
            end while (!taken);
        end
        in_valid <= 1'b0;
        in_last  <= 1'b0;
    endtask

    task automatic compare_output(input int n_replies);
        while (led_q.size() < n_replies) @(posedge clk);
        check_equal(32'(got_q.size()), 32'(exp_q.size()), "reply byte count");
        foreach (exp_q[i]) begin
            check_equal(32'(got_q[i]), 32'(exp_q[i]), $sformatf("byte %0d {last,data}", i));
        end
        foreach (exp_led_q[i]) begin
            check_equal(32'(led_q[i]), 32'(exp_led_q[i]), $sformatf("led after reply %0d", i));
        end
        got_q = {};
        exp_q = {};
        led_q = {};
        exp_led_q = {};
    endtask

    task automatic basic_echo();
        byte_q_t pay;
        byte_q_t f;
        random_payload(10, pay);
        build_request(LOCAL_IP, 16'h0800, 8'd17, ECHO_PORT, pay, f);
        expect_reply(pay);
        send_frame(f);
        compare_output(1);
    endtask

    task automatic drop_filtered();
        byte_q_t pay;
        byte_q_t f;
        random_payload(8, pay);
        build_request(LOCAL_IP, 16'h0800, 8'd17, ECHO_PORT + 16'd1, pay, f);
        send_frame(f);
        build_request(LOCAL_IP, 16'h86DD, 8'd17, ECHO_PORT, pay, f);
        send_frame(f);
        build_request(LOCAL_IP, 16'h0800, 8'd6, ECHO_PORT, pay, f);
        send_frame(f);
        build_request(LOCAL_IP + 32'd1, 16'h0800, 8'd17, ECHO_PORT, pay, f);
        send_frame(f);
        random_payload(12, pay);
        build_request(LOCAL_IP, 16'h0800, 8'd17, ECHO_PORT, pay, f);
        expect_reply(pay);
        send_frame(f);
        compare_output(1);
    endtask

    task automatic drop_short_frame();
        byte_q_t pay;
        byte_q_t f;
        random_payload(20, pay);
        build_request(LOCAL_IP, 16'h0800, 8'd17, ECHO_PORT, pay, f);
        f = f[0:29];
        send_frame(f);
        random_payload(6, pay);
        build_request(LOCAL_IP, 16'h0800, 8'd17, ECHO_PORT, pay, f);
        expect_reply(pay);
        send_frame(f);
        compare_output(1);
    endtask

    task automatic stalled_output();
        byte_q_t pay;
        byte_q_t f1;
        byte_q_t f2;
        random_payload(50, pay);
        build_request(LOCAL_IP, 16'h0800, 8'd17, ECHO_PORT, pay, f1);
        expect_reply(pay);
        random_payload(50, pay);
        build_request(LOCAL_IP, 16'h0800, 8'd17, ECHO_PORT, pay, f2);
        expect_reply(pay);
        @(negedge clk);
        stall_en = 1'b1;
        @(posedge clk);
        send_frame(f1);
        send_frame(f2);
        compare_output(2);
        @(negedge clk);
        stall_en = 1'b0;
        @(posedge clk);
    endtask

    task automatic led_display();
        byte_q_t pay;
        byte_q_t f;
        random_payload(5, pay);
        pay[0] = 8'hA5;
        build_request(LOCAL_IP, 16'h0800, 8'd17, ECHO_PORT, pay, f);
        expect_reply(pay);
        send_frame(f);
        compare_output(1);
        random_payload(5, pay);
        pay[0] = 8'h3C;
        build_request(LOCAL_IP, 16'h0800, 8'd17, ECHO_PORT, pay, f);
        expect_reply(pay);
        send_frame(f);
        compare_output(1);
    endtask

    // Sink side, random stalls only while enabled
    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            out_ready <= stall_en ? lfsr_bit() : 1'b1;
        end
    end

    // Output monitor, led sampled one cycle after each reply ends
    initial begin
        forever begin
            @(negedge clk);
            if (led_pending) begin
                led_q.push_back(led);
                led_pending = 1'b0;
            end
            if (!rst && out_valid && out_ready) begin
                got_q.push_back({out_last, out_data});
                if (out_last) led_pending = 1'b1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run timed out after %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst      = 1'b1;
        in_data  = 8'h00;
        in_valid = 1'b0;
        in_last  = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_equal(32'(led), 32'h0, "led after reset");
        @(posedge clk);
        basic_echo();
        drop_filtered();
        drop_short_frame();
        stalled_output();
        led_display();
        $display("No errors");
        $finish;
    end

endmodule

//--- flist.f
+incdir+src
src/net_hdr_pkg.sv
src/echo_ctl_pkg.sv
src/frame_header_parser.sv
src/echo_port_filter.sv
src/payload_fifo.sv
src/reply_framer.sv
src/udp_echo_top.sv
sim/udp_echo_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= udp_echo_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)
